// File: cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// bus and datapath widths
`define ADDR_W 32
`define DATA_W 32

// data memory depth in words
`define DMEM_WORDS 256

// one quotient bit per step
`define DIV_STEPS `DATA_W

`endif

// File: cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,
        OP_ALU   = 3'd1,
        OP_LOAD  = 3'd2,
        OP_STORE = 3'd3,
        OP_DIV   = 3'd4
    } op_kind_e;

    // operation held at the commit stage
    typedef struct packed {
        op_kind_e             kind;
        logic [4:0]           rd;
        logic                 reg_we;
        logic                 csr_we;
        logic                 mret;
        logic                 div_rem;   // 1 selects remainder
        logic [`ADDR_W-1:0]   addr;
        logic [`DATA_W-1:0]   opa;       // store data or dividend
        logic [`DATA_W-1:0]   opb;       // divisor
        logic [`DATA_W-1:0]   alu_res;
        logic [`DATA_W/8-1:0] strb;
    } exec_op_t;

    typedef struct packed {
        logic               valid;
        logic [4:0]         rd;
        logic               reg_we;
        logic               csr_we;
        logic [`DATA_W-1:0] data;
    } wb_t;

    // master to slave
    typedef struct packed {
        logic [`ADDR_W-1:0]   awaddr;
        logic [2:0]           awprot;
        logic                 awvalid;
        logic [`DATA_W-1:0]   wdata;
        logic [`DATA_W/8-1:0] wstrb;
        logic                 wvalid;
        logic                 bready;
        logic [`ADDR_W-1:0]   araddr;
        logic [2:0]           arprot;
        logic                 arvalid;
        logic                 rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic               awready;
        logic               wready;
        logic [1:0]         bresp;
        logic               bvalid;
        logic               arready;
        logic [`DATA_W-1:0] rdata;
        logic [1:0]         rresp;
        logic               rvalid;
    } axil_rsp_t;

    typedef struct packed {
        logic [`DATA_W-1:0] quot;
        logic [`DATA_W-1:0] rem;
    } div_res_t;

endpackage

// File: commit_ctrl.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module commit_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::exec_op_t   op_i,
    input  logic                trap_in_i,
    input  logic                trap_jump_i,
    input  logic                halt_req_i,
    input  logic                iram_rstn_i,
    output cpu_pkg::axil_req_t  axi_req_o,
    input  cpu_pkg::axil_rsp_t  axi_rsp_i,
    output logic                div_start_o,
    input  logic                div_ready_i,
    output logic                commit_o,
    output logic                reg_we_o,
    output logic                csr_we_o,
    output logic [`DATA_W-1:0]  load_data_o,
    output logic                iram_rd_o,
    output logic                trap_stat_o
);
    import cpu_pkg::*;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_WAIT = 1'b1
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   go;
    logic   is_load;
    logic   is_store;
    logic   is_div;
    logic   ar_hs;
    logic   r_hs;
    logic   wr_ok;
    logic   wait_done;

    // no trap, no halt, instruction memory out of reset
    assign go       = ~trap_in_i & ~halt_req_i & iram_rstn_i;
    assign is_load  = (op_i.kind == OP_LOAD);
    assign is_store = (op_i.kind == OP_STORE);
    assign is_div   = (op_i.kind == OP_DIV);

    assign ar_hs = axi_req_o.arvalid & axi_rsp_i.arready;
    assign r_hs  = axi_rsp_i.rvalid & axi_req_o.rready & (axi_rsp_i.rresp == 2'b00);
    assign wr_ok = axi_rsp_i.awready & axi_rsp_i.wready;  // store lands this edge

    assign wait_done = (is_load & r_hs) | (is_div & div_ready_i);

    assign div_start_o = (state_q == ST_IDLE) & go & is_div;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (go & (div_start_o | ar_hs)) begin
                    state_d = ST_WAIT;
                end
            end
            ST_WAIT: begin
                // abort drops back so the op is retried
                if (~go | wait_done) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_comb begin
        if (state_q == ST_IDLE) begin
            commit_o = go & ~is_load & ~is_div & (~is_store | wr_ok);
        end else begin
            commit_o = go & wait_done;
        end
    end

    // master channels straight from the op
    always_comb begin
        axi_req_o        = '0;
        axi_req_o.bready = 1'b1;
        axi_req_o.rready = 1'b1;
        load_data_o      = '0;
        if (state_q == ST_IDLE) begin
            axi_req_o.awaddr  = op_i.addr;
            axi_req_o.awvalid = go & is_store;
            axi_req_o.wdata   = op_i.opa;
            axi_req_o.wstrb   = op_i.strb;
            axi_req_o.wvalid  = go & is_store;
            axi_req_o.araddr  = op_i.addr;
            axi_req_o.arvalid = go & is_load;
        end else begin
            load_data_o = axi_rsp_i.rdata;  // only sampled on r_hs
        end
    end

    assign reg_we_o  = commit_o & op_i.reg_we;
    assign csr_we_o  = commit_o & op_i.csr_we;
    assign iram_rd_o = commit_o | trap_jump_i;  // fetch also follows a trap jump

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trap_stat_o <= 1'b0;
        end else if (!trap_stat_o) begin
            if (trap_jump_i) begin
                trap_stat_o <= 1'b1;  // entered handler
            end
        end else if (commit_o & op_i.mret) begin
            trap_stat_o <= 1'b0;  // handler returned
        end
    end

endmodule

// File: serial_divider.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module serial_divider (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_i,
    input  logic [`DATA_W-1:0]  dividend_i,
    input  logic [`DATA_W-1:0]  divisor_i,
    output logic                ready_o,
    output cpu_pkg::div_res_t   res_o
);

    localparam int CNT_W = $clog2(`DIV_STEPS + 1);

    logic               busy_q;
    logic               done_q;
    logic [CNT_W-1:0]   cnt_q;
    logic [`DATA_W-1:0] quo_q;
    logic [`DATA_W-1:0] rem_q;
    logic [`DATA_W-1:0] dsr_q;
    logic [`DATA_W:0]   rem_sh;
    logic [`DATA_W:0]   trial;

    // shift in next dividend bit and try the subtract
    assign rem_sh = {rem_q, quo_q[`DATA_W-1]};
    assign trial  = rem_sh - {1'b0, dsr_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;  // restart even if busy
                cnt_q  <= CNT_W'(`DIV_STEPS);
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == CNT_W'(1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;  // last step
                end
            end
        end
    end

    // a zero divisor never borrows, giving all ones and rem = dividend
    always_ff @(posedge clk) begin
        if (start_i) begin
            quo_q <= dividend_i;
            rem_q <= '0;
            dsr_q <= divisor_i;
        end else if (busy_q) begin
            if (!trial[`DATA_W]) begin
                rem_q <= trial[`DATA_W-1:0];
                quo_q <= {quo_q[`DATA_W-2:0], 1'b1};
            end else begin
                rem_q <= rem_sh[`DATA_W-1:0];
                quo_q <= {quo_q[`DATA_W-2:0], 1'b0};
            end
        end
    end

    assign ready_o    = done_q;
    assign res_o.quot = quo_q;
    assign res_o.rem  = rem_q;

endmodule

// File: axil_dmem.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module axil_dmem (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::axil_req_t  req_i,
    output cpu_pkg::axil_rsp_t  rsp_o
);

    localparam int IDX_W = $clog2(`DMEM_WORDS);
    localparam int NBYTE = `DATA_W / 8;

    logic [`DATA_W-1:0] mem [`DMEM_WORDS];
    logic               bvalid_q;
    logic               rvalid_q;
    logic [`DATA_W-1:0] rdata_q;
    logic               aw_ok;
    logic               w_ok;
    logic               ar_ok;
    logic [IDX_W-1:0]   wr_idx;
    logic [IDX_W-1:0]   rd_idx;

    // word index, byte offset dropped
    assign wr_idx = req_i.awaddr[IDX_W+1:2];
    assign rd_idx = req_i.araddr[IDX_W+1:2];

    assign rsp_o.awready = ~bvalid_q | req_i.bready;
    assign rsp_o.wready  = ~bvalid_q | req_i.bready;
    assign rsp_o.arready = ~rvalid_q;  // one read in flight
    assign rsp_o.bresp   = 2'b00;
    assign rsp_o.bvalid  = bvalid_q;
    assign rsp_o.rresp   = 2'b00;
    assign rsp_o.rvalid  = rvalid_q;
    assign rsp_o.rdata   = rdata_q;

    assign aw_ok = req_i.awvalid & rsp_o.awready;
    assign w_ok  = req_i.wvalid & rsp_o.wready;
    assign ar_ok = req_i.arvalid & rsp_o.arready;

    always_ff @(posedge clk) begin
        if (aw_ok & w_ok) begin
            for (int b = 0; b < NBYTE; b++) begin
                if (req_i.wstrb[b]) begin
                    mem[wr_idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_ok) begin
            rdata_q <= mem[rd_idx];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (aw_ok & w_ok) begin
                bvalid_q <= 1'b1;
            end else if (req_i.bready) begin
                bvalid_q <= 1'b0;
            end
            if (ar_ok) begin
                rvalid_q <= 1'b1;  // answer next cycle
            end else if (req_i.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

endmodule

// File: wb_stage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module wb_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                commit_i,
    input  cpu_pkg::exec_op_t   op_i,
    input  logic                reg_we_i,
    input  logic                csr_we_i,
    input  logic [`DATA_W-1:0]  load_data_i,
    input  cpu_pkg::div_res_t   div_res_i,
    output cpu_pkg::wb_t        wb_o
);
    import cpu_pkg::*;

    logic [`DATA_W-1:0] result;
    logic               valid_q;
    logic [4:0]         rd_q;
    logic               reg_we_q;
    logic               csr_we_q;
    logic [`DATA_W-1:0] data_q;

    always_comb begin
        case (op_i.kind)
            OP_LOAD: result = load_data_i;
            OP_DIV:  result = op_i.div_rem ? div_res_i.rem : div_res_i.quot;
            default: result = op_i.alu_res;  // alu, store and bubbles
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= commit_i;  // one strobe per commit
        end
    end

    always_ff @(posedge clk) begin
        if (commit_i) begin
            rd_q     <= op_i.rd;
            reg_we_q <= reg_we_i;
            csr_we_q <= csr_we_i;
            data_q   <= result;
        end
    end

    assign wb_o = '{valid: valid_q, rd: rd_q, reg_we: reg_we_q, csr_we: csr_we_q, data: data_q};

endmodule

// File: exec_backend_top.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module exec_backend_top (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::exec_op_t  op_i,
    input  logic               trap_in_i,
    input  logic               trap_jump_i,
    input  logic               halt_req_i,
    input  logic               iram_rstn_i,
    output logic               stall_o,
    output logic               iram_rd_o,
    output logic               trap_stat_o,
    output cpu_pkg::wb_t       wb_o
);
    import cpu_pkg::*;

    axil_req_t          axi_req;
    axil_rsp_t          axi_rsp;
    div_res_t           div_res;
    logic               div_start;
    logic               div_ready;
    logic               commit;
    logic               reg_we;
    logic               csr_we;
    logic [`DATA_W-1:0] load_data;

    assign stall_o = ~commit;  // upstream holds op while low

    commit_ctrl u_commit (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_i        (op_i),
        .trap_in_i   (trap_in_i),
        .trap_jump_i (trap_jump_i),
        .halt_req_i  (halt_req_i),
        .iram_rstn_i (iram_rstn_i),
        .axi_req_o   (axi_req),
        .axi_rsp_i   (axi_rsp),
        .div_start_o (div_start),
        .div_ready_i (div_ready),
        .commit_o    (commit),
        .reg_we_o    (reg_we),
        .csr_we_o    (csr_we),
        .load_data_o (load_data),
        .iram_rd_o   (iram_rd_o),
        .trap_stat_o (trap_stat_o)
    );

    serial_divider u_div (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (div_start),
        .dividend_i (op_i.opa),
        .divisor_i  (op_i.opb),
        .ready_o    (div_ready),
        .res_o      (div_res)
    );

    axil_dmem u_dmem (
        .clk   (clk),
        .rst_n (rst_n),
        .req_i (axi_req),
        .rsp_o (axi_rsp)
    );

    wb_stage u_wb (
        .clk         (clk),
        .rst_n       (rst_n),
        .commit_i    (commit),
        .op_i        (op_i),
        .reg_we_i    (reg_we),
        .csr_we_i    (csr_we),
        .load_data_i (load_data),
        .div_res_i   (div_res),
        .wb_o        (wb_o)
    );

endmodule

// File: exec_backend_asserts.sv
`timescale 1ns/1ps

module exec_backend_asserts (
    input logic               clk,
    input logic               rst_n,
    input cpu_pkg::exec_op_t  op_i,
    input logic               trap_in_i,
    input logic               trap_jump_i,
    input logic               halt_req_i,
    input logic               stall_o,
    input logic               iram_rd_o,
    input logic               trap_stat_o,
    input cpu_pkg::wb_t       wb_o,
    input cpu_pkg::axil_req_t axi_req,
    input logic               div_start,
    input logic               commit
);

    int fail_cnt = 0;

    reset_values: assert property (@(posedge clk) !rst_n |-> !wb_o.valid && !trap_stat_o
        && !axi_req.awvalid && !axi_req.wvalid && !axi_req.arvalid && !div_start)
        else begin $error("outputs not quiet during reset"); fail_cnt++; end

    // one strobe per commit, nothing in between
    wb_after_commit: assert property (@(posedge clk) disable iff (!rst_n)
        commit |=> wb_o.valid)
        else begin $error("commit gave no writeback"); fail_cnt++; end
    wb_only_on_commit: assert property (@(posedge clk) disable iff (!rst_n)
        !commit |=> !wb_o.valid)
        else begin $error("writeback without a commit"); fail_cnt++; end

    no_wb_when_blocked: assert property (@(posedge clk) disable iff (!rst_n)
        (halt_req_i || trap_in_i) |=> !wb_o.valid)
        else begin $error("writeback during halt or trap"); fail_cnt++; end

    fetch_rule: assert property (@(posedge clk) disable iff (!rst_n)
        iram_rd_o == (!stall_o || trap_jump_i))
        else begin $error("fetch enable does not follow stall and trap jump"); fail_cnt++; end

    trap_set: assert property (@(posedge clk) disable iff (!rst_n)
        (trap_jump_i && !trap_stat_o) |=> trap_stat_o)
        else begin $error("trap jump did not enter the handler"); fail_cnt++; end
    trap_clear: assert property (@(posedge clk) disable iff (!rst_n)
        (trap_stat_o && commit && op_i.mret) |=> !trap_stat_o)
        else begin $error("committed mret did not leave the handler"); fail_cnt++; end
    trap_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (trap_stat_o && !(commit && op_i.mret)) |=> trap_stat_o)
        else begin $error("handler left without a committed mret"); fail_cnt++; end

endmodule

bind exec_backend_top exec_backend_asserts u_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .op_i        (op_i),
    .trap_in_i   (trap_in_i),
    .trap_jump_i (trap_jump_i),
    .halt_req_i  (halt_req_i),
    .stall_o     (stall_o),
    .iram_rd_o   (iram_rd_o),
    .trap_stat_o (trap_stat_o),
    .wb_o        (wb_o),
    .axi_req     (axi_req),
    .div_start   (div_start),
    .commit      (commit)
);

// File: tb_exec_backend.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_exec_backend;
    import cpu_pkg::*;

    // each op gets at most one full divide plus an interruption
    localparam int N_OPS           = 31;
    localparam int OP_CYCLES       = `DIV_STEPS + 12;
    localparam int WATCHDOG_CYCLES = N_OPS * OP_CYCLES + 50;

    logic     clk;
    logic     rst_n;
    exec_op_t op_i;
    logic     trap_in_i;
    logic     trap_jump_i;
    logic     halt_req_i;
    logic     iram_rstn_i;
    logic     stall_o;
    logic     iram_rd_o;
    logic     trap_stat_o;
    wb_t      wb_o;

    int                 seed = 37;
    int                 errs = 0;
    int                 mark = 0;  // errs at start of current test
    int                 n_tests = 0;
    int                 n_failed = 0;
    logic [`DATA_W-1:0] shadow [`DMEM_WORDS];  // reference copy of the data memory

    exec_backend_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errs++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (errs == mark) begin
            $display("%s: pass", name);
        end else begin
            n_failed++;
            $display("%s: %0d errors", name, errs - mark);
        end
        mark = errs;
    endtask

    function automatic exec_op_t make_op(input op_kind_e kind);
        exec_op_t op;
        op        = '0;
        op.kind   = kind;
        op.rd     = 5'($random(seed));
        op.reg_we = 1'b1;
        return op;
    endfunction

    // RISC-V rule for a zero divisor
    function automatic logic [31:0] div_expect(input logic [31:0] a, input logic [31:0] b,
                                               input logic rem);
        if (b == 0) begin
            return rem ? a : 32'hffff_ffff;
        end
        return rem ? (a % b) : (a / b);
    endfunction

    task automatic set_hit(input int kind, input logic on);
        case (kind)
            0:       halt_req_i <= on;
            1:       trap_in_i <= on;
            default: iram_rstn_i <= ~on;  // active low
        endcase
    endtask

    // present op, optionally interrupt it, count stall cycles, fetch the writeback
    task automatic issue(input exec_op_t op, input int hit_at, input int hit_len,
                         input int hit_kind, output int stalls, output wb_t wb);
        int   cyc;
        logic done;
        @(posedge clk);
        op_i <= op;
        stalls = 0;
        cyc    = 0;
        done   = 1'b0;
        while (!done) begin
            if (cyc == hit_at) set_hit(hit_kind, 1'b1);
            if (cyc == hit_at + hit_len) set_hit(hit_kind, 1'b0);
            @(negedge clk);
            if (stall_o) begin
                stalls++;
                cyc++;
                @(posedge clk);
            end else begin
                done = 1'b1;  // commit cycle
            end
        end
        @(posedge clk);
        op_i <= '0;
        @(negedge clk);
        wb = wb_o;
        check("writeback valid", 1, wb.valid);
        check("writeback rd", 32'(op.rd), 32'(wb.rd));
        check("writeback reg_we", 32'(op.reg_we), 32'(wb.reg_we));
        check("writeback csr_we", 32'(op.csr_we), 32'(wb.csr_we));
    endtask

    task automatic store_word(input int idx, input logic [31:0] data, input logic [3:0] strb);
        exec_op_t op;
        wb_t      wb;
        int       stalls;
        op        = make_op(OP_STORE);
        op.reg_we = 1'b0;
        op.addr   = 32'(idx) << 2;
        op.opa    = data;
        op.strb   = strb;
        issue(op, -1, 0, 0, stalls, wb);
        check("store stall cycles", 0, stalls);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                shadow[idx][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    initial begin
        exec_op_t op;
        wb_t      wb;
        int       stalls;
        int       idx;
        rst_n       = 1'b0;
        op_i        = '0;
        trap_in_i   = 1'b0;
        trap_jump_i = 1'b0;
        halt_req_i  = 1'b0;
        iram_rstn_i = 1'b1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < 8; i++) begin
            op         = make_op(OP_ALU);
            op.alu_res = $random(seed);
            op.reg_we  = i[0];
            op.csr_we  = i[1];
            issue(op, -1, 0, 0, stalls, wb);
            check("alu data", op.alu_res, wb.data);
            check("alu stall cycles", 0, stalls);
        end
        end_test("alu");

        for (int i = 0; i < 4; i++) begin
            idx = (i * 61 + 5) % `DMEM_WORDS;
            store_word(idx, $random(seed), 4'hf);
            store_word(idx, $random(seed), 4'($random(seed)));  // partial merge
            op      = make_op(OP_LOAD);
            op.addr = 32'(idx) << 2;
            issue(op, -1, 0, 0, stalls, wb);
            check("load data", shadow[idx], wb.data);
            check("load stall cycles", 1, stalls);
        end
        end_test("store_load");

        for (int i = 0; i < 6; i++) begin
            op         = make_op(OP_DIV);
            op.opa     = $random(seed);
            op.opb     = (i < 2) ? 32'd0 : (32'($random(seed)) >> (i * 4));
            op.div_rem = i[0];
            issue(op, -1, 0, 0, stalls, wb);
            check("divide result", div_expect(op.opa, op.opb, op.div_rem), wb.data);
            check("divide stall cycles", `DIV_STEPS + 1, stalls);
        end
        end_test("divide");

        op      = make_op(OP_LOAD);
        op.addr = 32'(5) << 2;
        issue(op, 1, 3, 0, stalls, wb);  // halt while the read is pending
        check("halted load data", shadow[5], wb.data);
        check("halted load stall cycles", 5, stalls);
        op         = make_op(OP_DIV);
        op.opa     = 32'd1000003;
        op.opb     = 32'd97;
        op.div_rem = 1'b1;
        issue(op, 5, 2, 1, stalls, wb);  // trap mid divide
        check("trapped divide result", div_expect(op.opa, op.opb, 1'b1), wb.data);
        check("trapped divide stall cycles", 7 + `DIV_STEPS + 1, stalls);
        op         = make_op(OP_ALU);
        op.alu_res = $random(seed);
        issue(op, 0, 4, 0, stalls, wb);
        check("halted alu data", op.alu_res, wb.data);
        check("halted alu stall cycles", 4, stalls);
        end_test("halt_trap");

        @(posedge clk);
        halt_req_i  <= 1'b1;
        trap_jump_i <= 1'b1;  // jump while stalled
        @(negedge clk);
        check("iram_rd on jump", 1, iram_rd_o);
        check("stall on halt", 1, stall_o);
        @(posedge clk);
        halt_req_i  <= 1'b0;
        trap_jump_i <= 1'b0;
        @(negedge clk);
        check("trap_stat set", 1, trap_stat_o);
        op      = make_op(OP_ALU);
        op.mret = 1'b1;
        issue(op, 0, 3, 0, stalls, wb);  // halt holds back the mret
        check("mret stall cycles", 3, stalls);
        check("trap_stat cleared", 0, trap_stat_o);
        end_test("trap_state");

        op         = make_op(OP_ALU);
        op.alu_res = $random(seed);
        issue(op, 0, 5, 2, stalls, wb);
        check("iram reset stall cycles", 5, stalls);
        check("iram reset alu data", op.alu_res, wb.data);
        end_test("fetch_enable");

        repeat (3) @(posedge clk);
        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 n_tests, n_failed, errs, uut.u_asserts.fail_cnt);
        if (errs == 0 && uut.u_asserts.fail_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+.
cpu_pkg.sv
commit_ctrl.sv
serial_divider.sv
axil_dmem.sv
wb_stage.sv
exec_backend_top.sv
exec_backend_asserts.sv
tb_exec_backend.sv

// File: Makefile
LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_exec_backend -o sim_tb
	./obj_dir/sim_tb +verilator+error+limit+100 | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
